// ==== tile_defs.svh ====
// ####################
// Tile parameters: data and address widths, scratchpad geometry,
// engine register offsets and vector length limit
// ####################
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

`define TILE_DW          32        // One word, data and APB address
`define TILE_N_BANKS     4         // Scratchpad banks
`define TILE_BANK_WORDS  64        // Rows per bank
`define TILE_MEM_AW      8         // Scratchpad word address
`define TILE_MAX_LEN     32        // Longest vector the engine takes

// Engine register byte offsets, register space
`define TILE_REG_SRC_A   12'h000   // Operand A base word
`define TILE_REG_SRC_B   12'h004   // Operand B base word
`define TILE_REG_DST     12'h008   // Result word
`define TILE_REG_LEN     12'h00C   // Vector length
`define TILE_REG_CTRL    12'h010   // Bit 0 starts a run
`define TILE_REG_STATUS  12'h014   // Bit 0 busy, bit 1 done

`endif

// ==== tile_bus_pkg.sv ====
// ####################
// Bus types of the tile: scratchpad request/response
// and APB request/response
// ####################
`include "tile_defs.svh"

package tile_bus_pkg;

  // Master to scratchpad, held until gnt
  typedef struct packed {
    logic                    valid;  // Request pending
    logic                    we;     // Write when set
    logic [`TILE_MEM_AW-1:0] addr;   // Word address, low bits pick the bank
    logic [`TILE_DW-1:0]     wdata;
  } mem_req_t;

  // Scratchpad to master
  typedef struct packed {
    logic                gnt;     // Same cycle as the request
    logic                rvalid;  // One cycle after a granted read
    logic [`TILE_DW-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [`TILE_DW-1:0] paddr;   // Byte address
    logic [`TILE_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                pready;
    logic                pslverr;  // Only meaningful with pready
    logic [`TILE_DW-1:0] prdata;
  } apb_rsp_t;

endpackage

// ==== tile_engine_pkg.sv ====
// ####################
// Engine types: run configuration and the two
// decodes of an APB address word
// ####################
`include "tile_defs.svh"

package tile_engine_pkg;

  typedef struct packed {
    logic [`TILE_DW-1:0] src_a;  // Word address of A[0]
    logic [`TILE_DW-1:0] src_b;  // Word address of B[0]
    logic [`TILE_DW-1:0] dst;    // Word address of the sum
    logic [`TILE_DW-1:0] len;    // Element count, at most TILE_MAX_LEN
  } eng_cfg_t;

  typedef struct packed {
    logic [18:0] rsvd;
    logic        space;  // Clear for registers
    logic [11:0] off;    // Register byte offset
  } apb_reg_view_t;

  typedef struct packed {
    logic [18:0]               rsvd;
    logic                      space;  // Set for scratchpad
    logic [9-`TILE_MEM_AW:0]   ovf;    // Word index beyond the scratchpad
    logic [`TILE_MEM_AW-1:0]   waddr;  // Row above bank bits
    logic [1:0]                bsel;   // Byte lane, words only
  } apb_mem_view_t;

  typedef union packed {
    apb_reg_view_t regs;
    apb_mem_view_t mem;
  } apb_addr_u;

endpackage

// ==== apb_host_port.sv ====
// ####################
// APB slave of the tile: engine registers, scratchpad
// access through the arbiter, error responses
// ####################
`timescale 1ns/1ps
`include "tile_defs.svh"

module apb_host_port (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  tile_bus_pkg::apb_req_t    apb_req_i,
  output tile_bus_pkg::apb_rsp_t    apb_rsp_o,
  output tile_engine_pkg::eng_cfg_t cfg_o,
  output logic                      start_o,
  input  logic                      busy_i,
  input  logic                      done_i,
  output tile_bus_pkg::mem_req_t    mem_req_o,
  input  tile_bus_pkg::mem_rsp_t    mem_rsp_i
);

  localparam int unsigned MEM_WORDS = `TILE_N_BANKS * `TILE_BANK_WORDS;

  tile_engine_pkg::apb_addr_u addr;
  tile_engine_pkg::eng_cfg_t  cfg_q;
  logic                       access, reg_acc, mem_acc, mem_oob;
  logic                       reg_known, ctrl_wr, ctrl_busy;
  logic                       rd_pend_q;  // Host read granted, data next
  logic                       done_q;
  logic [9:0]                 mem_word;
  logic [`TILE_DW-1:0]        reg_rdata;

  assign addr      = apb_req_i.paddr;
  assign access    = apb_req_i.psel & apb_req_i.penable;  // Access phase
  assign reg_acc   = access & ~addr.regs.space;
  assign mem_acc   = access & addr.mem.space;
  assign mem_word  = {addr.mem.ovf, addr.mem.waddr};
  assign mem_oob   = 32'(mem_word) > MEM_WORDS - 1;
  assign ctrl_wr   = reg_acc & apb_req_i.pwrite & (addr.regs.off == `TILE_REG_CTRL);
  assign ctrl_busy = ctrl_wr & busy_i;                     // Rejected run request
  assign start_o   = ctrl_wr & ~busy_i & apb_req_i.pwdata[0];
  assign cfg_o     = cfg_q;

  always_comb begin
    reg_known = 1'b1;
    reg_rdata = '0;
    case (addr.regs.off)
      `TILE_REG_SRC_A:  reg_rdata = cfg_q.src_a;
      `TILE_REG_SRC_B:  reg_rdata = cfg_q.src_b;
      `TILE_REG_DST:    reg_rdata = cfg_q.dst;
      `TILE_REG_LEN:    reg_rdata = cfg_q.len;
      `TILE_REG_CTRL:   reg_rdata = '0;                    // Trigger only
      `TILE_REG_STATUS: reg_rdata = {{(`TILE_DW-2){1'b0}}, done_q, busy_i};
      default:          reg_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cfg_q <= '0;
    end else if (reg_acc && apb_req_i.pwrite) begin
      case (addr.regs.off)
        `TILE_REG_SRC_A: cfg_q.src_a <= apb_req_i.pwdata;
        `TILE_REG_SRC_B: cfg_q.src_b <= apb_req_i.pwdata;
        `TILE_REG_DST:   cfg_q.dst   <= apb_req_i.pwdata;
        `TILE_REG_LEN:   cfg_q.len   <= (apb_req_i.pwdata > `TILE_MAX_LEN) ?
                                        `TILE_DW'(`TILE_MAX_LEN) : apb_req_i.pwdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      done_q    <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      if (start_o)     done_q <= 1'b0;  // New run wins over a finishing one
      else if (done_i) done_q <= 1'b1;
      if (mem_req_o.valid && !mem_req_o.we && mem_rsp_i.gnt) rd_pend_q <= 1'b1;
      else if (mem_rsp_i.rvalid)                             rd_pend_q <= 1'b0;
    end
  end

  // APB holds address and data until pready, so the request stays stable
  always_comb begin
    mem_req_o.valid = mem_acc & ~mem_oob & ~rd_pend_q;
    mem_req_o.we    = apb_req_i.pwrite;
    mem_req_o.addr  = addr.mem.waddr;
    mem_req_o.wdata = apb_req_i.pwdata;
  end

  always_comb begin
    apb_rsp_o = '0;
    if (reg_acc) begin
      apb_rsp_o.pready  = 1'b1;                            // First access cycle
      apb_rsp_o.pslverr = ~reg_known | ctrl_busy;
      apb_rsp_o.prdata  = reg_rdata;
    end else if (mem_acc && mem_oob) begin
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = 1'b1;
    end else if (mem_acc) begin
      apb_rsp_o.pready  = apb_req_i.pwrite ? mem_rsp_i.gnt : (rd_pend_q & mem_rsp_i.rvalid);
      apb_rsp_o.prdata  = mem_rsp_i.rdata;
    end
  end

  // Read data is due one cycle after a granted host read
  a_rd_return: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rd_pend_q |-> mem_rsp_i.rvalid);

endmodule

// ==== tcdm_arbiter.sv ====
// ####################
// Round-robin arbiter, host port and engine
// sharing the scratchpad
// ####################
`timescale 1ns/1ps

module tcdm_arbiter (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  tile_bus_pkg::mem_req_t host_req_i,
  output tile_bus_pkg::mem_rsp_t host_rsp_o,
  input  tile_bus_pkg::mem_req_t eng_req_i,
  output tile_bus_pkg::mem_rsp_t eng_rsp_o,
  output tile_bus_pkg::mem_req_t mem_req_o,
  input  tile_bus_pkg::mem_rsp_t mem_rsp_i
);

  logic last_eng_q;  // Engine took the last grant
  logic own_eng_q;   // Engine owns the read returning now
  logic host_win, eng_win;

  // Host wins alone, or on a tie when the engine went last
  assign host_win  = host_req_i.valid & (~eng_req_i.valid | last_eng_q);
  assign eng_win   = eng_req_i.valid & ~host_win;
  assign mem_req_o = host_win ? host_req_i : eng_req_i;  // Idle engine has valid low

  always_comb begin
    host_rsp_o.gnt    = host_win & mem_rsp_i.gnt;
    host_rsp_o.rvalid = mem_rsp_i.rvalid & ~own_eng_q;
    host_rsp_o.rdata  = mem_rsp_i.rdata;
    eng_rsp_o.gnt     = eng_win & mem_rsp_i.gnt;
    eng_rsp_o.rvalid  = mem_rsp_i.rvalid & own_eng_q;
    eng_rsp_o.rdata   = mem_rsp_i.rdata;
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      last_eng_q <= 1'b0;
      own_eng_q  <= 1'b0;
    end else if (mem_req_o.valid && mem_rsp_i.gnt) begin
      last_eng_q <= eng_win;
      if (!mem_req_o.we) own_eng_q <= eng_win;  // Steers next cycle's rvalid
    end
  end

  // Each read returns to the master granted it one cycle before
  a_host_rvalid: assert property (@(posedge clk_i) disable iff (!rstn_i)
    host_rsp_o.gnt && !host_req_i.we |=> host_rsp_o.rvalid);

  a_eng_rvalid: assert property (@(posedge clk_i) disable iff (!rstn_i)
    eng_rsp_o.gnt && !eng_req_i.we |=> eng_rsp_o.rvalid);

  // A held host request that lost the tie wins next
  a_host_turn: assert property (@(posedge clk_i) disable iff (!rstn_i)
    host_req_i.valid && !host_rsp_o.gnt |=> host_rsp_o.gnt);

endmodule

// ==== l1_spm.sv ====
// ####################
// Word-interleaved banked scratchpad,
// read data one cycle after the request
// ####################
`timescale 1ns/1ps
`include "tile_defs.svh"

module l1_spm (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  tile_bus_pkg::mem_req_t mem_req_i,
  output tile_bus_pkg::mem_rsp_t mem_rsp_o
);

  localparam int unsigned BANK_BITS = $clog2(`TILE_N_BANKS);
  localparam int unsigned ROW_BITS  = `TILE_MEM_AW - BANK_BITS;

  logic [BANK_BITS-1:0] bank_sel;
  logic [ROW_BITS-1:0]  row_sel;
  logic [`TILE_DW-1:0]  bank_rdata [`TILE_N_BANKS];
  logic [`TILE_DW-1:0]  rdata_q;
  logic                 rvalid_q;

  assign bank_sel = mem_req_i.addr[BANK_BITS-1:0];            // Neighbour words in neighbour banks
  assign row_sel  = mem_req_i.addr[`TILE_MEM_AW-1:BANK_BITS];

  for (genvar b = 0; b < `TILE_N_BANKS; b++) begin : g_bank
    logic [`TILE_DW-1:0] ram [`TILE_BANK_WORDS] = '{default: '0};
    logic                bank_we;

    assign bank_we       = mem_req_i.valid & mem_req_i.we & (bank_sel == BANK_BITS'(b));
    assign bank_rdata[b] = ram[row_sel];

    always_ff @(posedge clk_i) begin
      if (bank_we) ram[row_sel] <= mem_req_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_req_i.valid && !mem_req_i.we) rdata_q <= bank_rdata[bank_sel];
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) rvalid_q <= 1'b0;
    else         rvalid_q <= mem_req_i.valid & ~mem_req_i.we;
  end

  assign mem_rsp_o.gnt    = mem_req_i.valid;  // No bank conflicts with one port
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.rdata  = rdata_q;

endmodule

// ==== dot_engine.sv ====
// ####################
// Dot-product engine, reads A[i] and B[i] from the
// scratchpad, sums the products mod 2^32, stores the sum
// ####################
`timescale 1ns/1ps
`include "tile_defs.svh"

module dot_engine (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  tile_engine_pkg::eng_cfg_t cfg_i,
  input  logic                      start_i,
  output tile_bus_pkg::mem_req_t    mem_req_o,
  input  tile_bus_pkg::mem_rsp_t    mem_rsp_i,
  output logic                      busy_o,
  output logic                      evt_o
);

  localparam int unsigned IDX_W = $clog2(`TILE_MAX_LEN + 1);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_FETCH_A = 3'd1;  // Request A[i]
  localparam logic [2:0] S_FETCH_B = 3'd2;  // A[i] returns, request B[i]
  localparam logic [2:0] S_ACC     = 3'd3;  // B[i] returns, accumulate
  localparam logic [2:0] S_STORE   = 3'd4;
  localparam logic [2:0] S_DONE    = 3'd5;  // One-cycle event

  logic [2:0]                state_q;
  tile_engine_pkg::eng_cfg_t cfg_q;        // Frozen at start
  logic [IDX_W-1:0]          idx_q;
  logic [`TILE_DW-1:0]       acc_q, op_a_q;
  logic                      last;

  assign busy_o = (state_q != S_IDLE) && (state_q != S_DONE);
  assign evt_o  = state_q == S_DONE;
  assign last   = (`TILE_DW'(idx_q) + 1'b1) == cfg_q.len;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= S_IDLE;
      idx_q   <= '0;
      acc_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE, S_DONE: begin
          state_q <= S_IDLE;
          if (start_i) begin                  // A start in S_DONE begins the next run
            idx_q   <= '0;
            acc_q   <= '0;
            state_q <= (cfg_i.len == '0) ? S_STORE : S_FETCH_A;
          end
        end
        S_FETCH_A: if (mem_rsp_i.gnt) state_q <= S_FETCH_B;
        S_FETCH_B: if (mem_rsp_i.gnt) state_q <= S_ACC;
        S_ACC: begin
          acc_q   <= acc_q + op_a_q * mem_rsp_i.rdata;  // Wraps at 32 bits
          idx_q   <= idx_q + 1'b1;
          state_q <= last ? S_STORE : S_FETCH_A;
        end
        S_STORE: if (mem_rsp_i.gnt) state_q <= S_DONE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && !busy_o)                           cfg_q  <= cfg_i;
    if (state_q == S_FETCH_B && mem_rsp_i.rvalid)     op_a_q <= mem_rsp_i.rdata;
  end

  always_comb begin
    mem_req_o = '0;
    case (state_q)
      S_FETCH_A: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.addr  = cfg_q.src_a[`TILE_MEM_AW-1:0] + `TILE_MEM_AW'(idx_q);
      end
      S_FETCH_B: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.addr  = cfg_q.src_b[`TILE_MEM_AW-1:0] + `TILE_MEM_AW'(idx_q);
      end
      S_STORE: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = cfg_q.dst[`TILE_MEM_AW-1:0];
        mem_req_o.wdata = acc_q;
      end
      default: ;
    endcase
  end

  // Host port must hold off CTRL writes during a run
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
    start_i |-> !busy_o);

endmodule

// ==== tile_top.sv ====
// ####################
// Compute tile: APB host port and dot engine
// sharing the banked scratchpad
// ####################
`timescale 1ns/1ps

module tile_top (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  tile_bus_pkg::apb_req_t apb_req_i,
  output tile_bus_pkg::apb_rsp_t apb_rsp_o,
  output logic                   busy_o,
  output logic                   evt_o
);

  tile_bus_pkg::mem_req_t    host_req, eng_req, spm_req;
  tile_bus_pkg::mem_rsp_t    host_rsp, eng_rsp, spm_rsp;
  tile_engine_pkg::eng_cfg_t eng_cfg;
  logic                      eng_start;

  apb_host_port i_host_port (
    .clk_i     ( clk_i     ),
    .rstn_i    ( rstn_i    ),
    .apb_req_i ( apb_req_i ),
    .apb_rsp_o ( apb_rsp_o ),
    .cfg_o     ( eng_cfg   ),
    .start_o   ( eng_start ),
    .busy_i    ( busy_o    ),
    .done_i    ( evt_o     ),  // Event sets the done flag
    .mem_req_o ( host_req  ),
    .mem_rsp_i ( host_rsp  )
  );

  dot_engine i_dot_engine (
    .clk_i     ( clk_i     ),
    .rstn_i    ( rstn_i    ),
    .cfg_i     ( eng_cfg   ),
    .start_i   ( eng_start ),
    .mem_req_o ( eng_req   ),
    .mem_rsp_i ( eng_rsp   ),
    .busy_o    ( busy_o    ),
    .evt_o     ( evt_o     )
  );

  tcdm_arbiter i_arbiter (
    .clk_i      ( clk_i    ),
    .rstn_i     ( rstn_i   ),
    .host_req_i ( host_req ),
    .host_rsp_o ( host_rsp ),
    .eng_req_i  ( eng_req  ),
    .eng_rsp_o  ( eng_rsp  ),
    .mem_req_o  ( spm_req  ),
    .mem_rsp_i  ( spm_rsp  )
  );

  l1_spm i_l1_spm (
    .clk_i     ( clk_i   ),
    .rstn_i    ( rstn_i  ),
    .mem_req_i ( spm_req ),
    .mem_rsp_o ( spm_rsp )
  );

endmodule

// ==== tb_tile.sv ====
// ####################
// Testbench of the compute tile: scratchpad walk, dot-product
// runs from the pattern file, host contention, APB errors
// ####################
`timescale 1ns/1ps
`include "tile_defs.svh"

module tb_tile;

  localparam int MEM_WORDS  = `TILE_N_BANKS * `TILE_BANK_WORDS;
  localparam int PROBE_BASE = 192;  // Host-only area, never touched by the engine

  logic                   clk_i;
  logic                   rstn_i;
  tile_bus_pkg::apb_req_t apb_req;
  tile_bus_pkg::apb_rsp_t apb_rsp;
  logic                   busy_o, evt_o;

  logic [31:0] pat   [64];                // Pattern file image
  logic [31:0] model [MEM_WORDS];         // Last value written per word
  logic [31:0] vec_a [`TILE_MAX_LEN];
  logic [31:0] vec_b [`TILE_MAX_LEN];
  integer      seed;
  int          cycles = 0;
  int          limit  = 1000000;
  int          evt_cnt = 0;
  logic        busy_seen = 1'b0;

  tile_top dut (
    .clk_i     ( clk_i   ),
    .rstn_i    ( rstn_i  ),
    .apb_req_i ( apb_req ),
    .apb_rsp_o ( apb_rsp ),
    .busy_o    ( busy_o  ),
    .evt_o     ( evt_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycles);
      $display("TB FAILED");
      $fatal(1, "Timeout");
    end
  end

  // Sampled mid-cycle, away from the DUT's clock edge
  always @(negedge clk_i) begin
    if (rstn_i && evt_o)  evt_cnt = evt_cnt + 1;
    if (rstn_i && busy_o) busy_seen = 1'b1;
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("TB FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  function automatic logic [31:0] fill_word(input int w);
    logic [7:0] a;
    a = 8'(w);
    return {~a, a, a ^ 8'hA5, a + 8'h3C};  // Every byte follows the address
  endfunction

  function automatic logic [31:0] mem_addr(input int w);
    return 32'h0000_1000 + 32'(w) * 32'd4;  // Bit 12 picks the scratchpad
  endfunction

  // Wrapped sum of products over the loaded vectors
  function automatic logic [31:0] dot_ref(input int len);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < len; i++) sum = sum + vec_a[i] * vec_b[i];
    return sum;
  endfunction

  function automatic int cycle_budget(input int len);
    return 8 * (2 * len + 16) + 4 * (2 * len + 2);  // APB transfers plus engine time
  endfunction

  // Setup, then access until pready, sampled on the falling edge
  task automatic do_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    while (!apb_rsp.pready) @(negedge clk_i);  // Longer under engine traffic
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk_i);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata, output logic err);
    logic [31:0] unused;
    do_transfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata, output logic err);
    do_transfer(1'b0, addr, 32'h0, rdata, err);
  endtask

  task automatic write_word(input int w, input logic [31:0] data);
    logic err;
    apb_write(mem_addr(w), data, err);
    check_eq(32'(err), 32'h0, "pslverr on scratchpad write");
    model[w] = data;
  endtask

  task automatic read_check(input int w, input string msg);
    logic [31:0] rd;
    logic        err;
    apb_read(mem_addr(w), rd, err);
    check_eq(32'(err), 32'h0, "pslverr on scratchpad read");
    check_eq(rd, model[w], msg);
  endtask

  task automatic set_reg(input logic [11:0] off, input logic [31:0] val);
    logic err;
    apb_write({20'h0, off}, val, err);
    check_eq(32'(err), 32'h0, "pslverr on register write");
  endtask

  // Load vectors, program, start, contend, then check STATUS and the result
  task automatic run_dot(input int len, input int src_a, input int src_b, input int dst,
                         input logic [31:0] expected);
    logic [31:0] rd;
    logic        err;
    int          evt_before;
    for (int i = 0; i < len; i++) write_word(src_a + i, vec_a[i]);
    for (int i = 0; i < len; i++) write_word(src_b + i, vec_b[i]);
    set_reg(`TILE_REG_SRC_A, 32'(src_a));
    set_reg(`TILE_REG_SRC_B, 32'(src_b));
    set_reg(`TILE_REG_DST, 32'(dst));
    set_reg(`TILE_REG_LEN, 32'(len));
    evt_before = evt_cnt;
    busy_seen  = 1'b0;
    set_reg(`TILE_REG_CTRL, 32'h1);
    if (len >= 4) begin                        // Long enough to still be running here
      apb_read({20'h0, `TILE_REG_STATUS}, rd, err);
      check_eq(rd, 32'h1, "STATUS during run");
      apb_write({20'h0, `TILE_REG_CTRL}, 32'h1, err);
      check_eq(32'(err), 32'h1, "pslverr on CTRL write while busy");
    end
    while (evt_cnt == evt_before) begin
      read_check(PROBE_BASE + int'($random(seed) & 63), "host read during engine run");
    end
    repeat (2) @(negedge clk_i);
    check_eq(32'(evt_cnt - evt_before), 32'h1, "evt_o pulses per run");
    check_eq(32'(busy_seen), 32'h1, "busy_o raised during run");
    apb_read({20'h0, `TILE_REG_STATUS}, rd, err);
    check_eq(rd, 32'h2, "STATUS after run");
    model[dst] = expected;
    read_check(dst, "dot product at DST");
  endtask

  initial begin
    int          ptr;
    int          len;
    int          budget;
    logic [31:0] rd;
    logic        err;
    seed    = 32'ha137_dfc0;
    apb_req = '0;
    rstn_i  = 1'b0;
    $readmemh("tile_patterns.hex", pat);
    budget = 2 * MEM_WORDS * 8 + 64 + cycle_budget(`TILE_MAX_LEN);  // Walk, probes, random run
    ptr    = 1;
    for (int p = 0; p < int'(pat[0]); p++) begin
      len    = int'(pat[ptr]);
      budget = budget + cycle_budget(len);
      ptr    = ptr + 5 + 2 * len;
    end
    limit = 4 * budget;
    repeat (3) @(posedge clk_i);
    rstn_i <= 1'b1;
    @(negedge clk_i);
    check_eq(32'(apb_rsp.pready), 32'h0, "pready after reset");
    check_eq(32'(busy_o), 32'h0, "busy_o after reset");
    check_eq(32'(evt_o), 32'h0, "evt_o after reset");

    for (int w = 0; w < MEM_WORDS; w++) write_word(w, fill_word(w));
    for (int w = 0; w < MEM_WORDS; w++) read_check(w, "scratchpad walk readback");

    ptr = 1;
    for (int p = 0; p < int'(pat[0]); p++) begin
      len = int'(pat[ptr]);
      for (int i = 0; i < len; i++) begin
        vec_a[i] = pat[ptr + 5 + i];
        vec_b[i] = pat[ptr + 5 + len + i];
      end
      check_eq(dot_ref(len), pat[ptr + 4], "pattern file sum");
      run_dot(len, int'(pat[ptr + 1]), int'(pat[ptr + 2]), int'(pat[ptr + 3]), pat[ptr + 4]);
      ptr = ptr + 5 + 2 * len;
    end

    for (int i = 0; i < `TILE_MAX_LEN; i++) begin
      vec_a[i] = $random(seed);
      vec_b[i] = $random(seed);
    end
    run_dot(`TILE_MAX_LEN, 0, 64, 132, dot_ref(`TILE_MAX_LEN));

    apb_read(pat[ptr], rd, err);                           // Unknown register offset
    check_eq(32'(err), 32'h1, "pslverr on unknown register");
    apb_write(pat[ptr + 1], 32'hDEAD_BEEF, err);           // One word past the scratchpad
    check_eq(32'(err), 32'h1, "pslverr on out-of-range write");
    apb_read(pat[ptr + 1], rd, err);
    check_eq(32'(err), 32'h1, "pslverr on out-of-range read");
    read_check(0, "word 0 after out-of-range write");

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== tile_patterns.hex ====
// Word 0 is the pattern count; each pattern is len src_a src_b dst sum, then A words, B words
// The last two words are an unknown register address and an out-of-range scratchpad address
00000004
// len 4, small values
00000004 00000000 00000040 00000080 00000046
00000001 00000002 00000003 00000004
00000005 00000006 00000007 00000008
// len 3, products and sum wrap at 32 bits
00000003 00000010 00000050 00000081 7FFFFFFE
FFFFFFFF 00010000 80000000
00000002 00010000 00000003
// len 0 stores zero
00000000 00000020 00000060 00000082 00000000
// len 5, vectors start off bank 0
00000005 00000003 00000045 00000083 00002486
0000000A 00000014 0000001E 00000028 00000032
00000011 00000022 00000033 00000044 00000055
// Error probes
00000020
00001400

// ==== flist.f ====
+incdir+.
tile_bus_pkg.sv
tile_engine_pkg.sv
apb_host_port.sv
tcdm_arbiter.sv
l1_spm.sv
dot_engine.sv
tile_top.sv
tb_tile.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_tile -f flist.f -o tb_tile_sim &&
./obj_dir/tb_tile_sim || exit 1
